/* hw/memStagePkg.sv */
package memStagePkg;

    // load access kinds, U variants zero-extend
    typedef enum logic [2:0] {
        ldNone  = 3'd0,
        ldByte  = 3'd1,
        ldByteU = 3'd2,
        ldHalf  = 3'd3,
        ldHalfU = 3'd4,
        ldWord  = 3'd5
    } loadType;

    typedef enum logic [1:0] {
        stNone = 2'd0,
        stByte = 2'd1,
        stHalf = 2'd2,
        stWord = 2'd3
    } storeType;

    // values match the MIPS cause register ExcCode field
    typedef enum logic [4:0] {
        excNone = 5'd0,
        excAdEL = 5'd4,
        excAdES = 5'd5
    } excCode;

    // execute stage output, registered into the memory stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic [31:0] storeData;
        loadType     ldType;
        storeType    stType;
        logic [4:0]  dst;
        logic        regWr;
    } exeMemBus;

    // toward writeback and the forwarding muxes
    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  dst;
        logic        regWr;
    } memWbBus;

endpackage

/* hw/memStageReg.sv */
`timescale 1ns/1ps

module memStageReg (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  stageWr,
    input  logic                  stageFlush,
    input  memStagePkg::exeMemBus exeIn,
    output memStagePkg::exeMemBus memIn
);
    import memStagePkg::*;

    // control part, cleared by reset and flush
    logic        validQ;
    logic        regWrQ;
    loadType     ldTypeQ;
    storeType    stTypeQ;

    // payload part
    logic [31:0] pcQ;
    logic [31:0] aluOutQ;
    logic [31:0] storeDataQ;
    logic [4:0]  dstQ;

    // flush has priority over advance, otherwise hold
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ  <= 1'b0;
            regWrQ  <= 1'b0;
            ldTypeQ <= ldNone;
            stTypeQ <= stNone;
        end else if (stageFlush) begin
            validQ  <= 1'b0;
            regWrQ  <= 1'b0;
            ldTypeQ <= ldNone;
            stTypeQ <= stNone;
        end else if (stageWr) begin
            validQ  <= exeIn.valid;
            regWrQ  <= exeIn.regWr;
            ldTypeQ <= exeIn.ldType;
            stTypeQ <= exeIn.stType;
        end
    end

    // payload of a bubble is don't-care, the control part makes it inert
    always_ff @(posedge clk) begin
        if (stageWr) begin
            pcQ        <= exeIn.pc;
            aluOutQ    <= exeIn.aluOut;
            storeDataQ <= exeIn.storeData;
            dstQ       <= exeIn.dst;
        end
    end

    always_comb begin
        memIn.valid     = validQ;
        memIn.pc        = pcQ;
        memIn.aluOut    = aluOutQ;
        memIn.storeData = storeDataQ;
        memIn.ldType    = ldTypeQ;
        memIn.stType    = stTypeQ;
        memIn.dst       = dstQ;
        memIn.regWr     = regWrQ;
    end

    // decode upstream must never issue a combined load and store
    assert property (@(posedge clk) disable iff (!arstN)
        !(memIn.ldType != ldNone && memIn.stType != stNone));

endmodule

/* hw/storeAlign.sv */
`timescale 1ns/1ps

module storeAlign (
    input  memStagePkg::storeType stType,
    input  logic [1:0]            addrLow,
    input  logic [31:0]           storeData,
    output logic [3:0]            byteEn,
    output logic [31:0]           wrData
);
    import memStagePkg::*;

    // lane order is little-endian, lane 0 holds bits 7:0
    always_comb begin
        byteEn = 4'b0000;
        wrData = storeData;
        case (stType)
            stByte: begin
                // same byte on every lane, enable picks one
                wrData = {4{storeData[7:0]}};
                byteEn = 4'b0001 << addrLow;
            end
            stHalf: begin
                wrData = {2{storeData[15:0]}};
                if (addrLow[1]) begin
                    byteEn = 4'b1100;
                end else begin
                    byteEn = 4'b0011;
                end
            end
            stWord: begin
                wrData = storeData;
                byteEn = 4'b1111;
            end
            default: begin
                // stNone writes nothing
                byteEn = 4'b0000;
            end
        endcase
    end

endmodule

/* hw/loadAlign.sv */
`timescale 1ns/1ps

module loadAlign (
    input  memStagePkg::loadType ldType,
    input  logic [1:0]           addrLow,
    input  logic [31:0]          rdWord,
    output logic [31:0]          loadData
);
    import memStagePkg::*;

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // byte and half picked by the low address bits
    always_comb begin
        case (addrLow)
            2'd0:    byteSel = rdWord[7:0];
            2'd1:    byteSel = rdWord[15:8];
            2'd2:    byteSel = rdWord[23:16];
            default: byteSel = rdWord[31:24];
        endcase
    end

    // bit 0 is ignored here, a misaligned half is trapped elsewhere
    assign halfSel = addrLow[1] ? rdWord[31:16] : rdWord[15:0];

    always_comb begin
        case (ldType)
            ldByte: begin
                loadData = {{24{byteSel[7]}}, byteSel};
            end
            ldByteU: begin
                loadData = {24'd0, byteSel};
            end
            ldHalf: begin
                loadData = {{16{halfSel[15]}}, halfSel};
            end
            ldHalfU: begin
                loadData = {16'd0, halfSel};
            end
            default: begin
                // word load, and a harmless value when no load
                loadData = rdWord;
            end
        endcase
    end

endmodule

/* hw/dataRam.sv */
`timescale 1ns/1ps

module dataRam #(
    parameter int ramAddrBits = 8
) (
    input  logic                   clk,
    input  logic [3:0]             byteEn,
    input  logic [31:0]            wrData,
    input  logic [ramAddrBits-1:0] wordAddr,
    output logic [31:0]            rdWord
);

    localparam int ramWords = 2 ** ramAddrBits;

    logic [31:0] mem [ramWords];

    // per-lane write on the rising edge
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (byteEn[lane]) begin
                mem[wordAddr][8*lane +: 8] <= wrData[8*lane +: 8];
            end
        end
    end

    // zero-latency read, a store shows up from the next cycle on
    assign rdWord = mem[wordAddr];

    // an X address on a write would corrupt an unknown word
    assert property (@(posedge clk)
        (byteEn != 4'b0000) |-> !$isunknown(wordAddr));

endmodule

/* hw/memExcept.sv */
`timescale 1ns/1ps

module memExcept (
    input  logic                  clk,
    input  logic                  arstN,
    input  memStagePkg::exeMemBus memIn,
    output logic                  addrErr,
    output logic                  flushException,
    output memStagePkg::excCode   excOut,
    output logic [31:0]           epc,
    output logic [31:0]           badVAddr
);
    import memStagePkg::*;

    logic halfAccess;
    logic wordAccess;
    logic misAligned;

    assign halfAccess = (memIn.ldType inside {ldHalf, ldHalfU}) || (memIn.stType == stHalf);
    assign wordAccess = (memIn.ldType == ldWord) || (memIn.stType == stWord);

    assign misAligned = (halfAccess && memIn.aluOut[0])
                     || (wordAccess && (memIn.aluOut[1:0] != 2'b00));

    assign addrErr        = memIn.valid && misAligned;
    assign flushException = addrErr;

    // stores report AdES and loads AdEL
    always_comb begin
        if (!addrErr) begin
            excOut = excNone;
        end else if (memIn.stType != stNone) begin
            excOut = excAdES;
        end else begin
            excOut = excAdEL;
        end
    end

    // cp0 style capture of the faulting instruction
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            epc      <= 32'd0;
            badVAddr <= 32'd0;
        end else if (addrErr) begin
            epc      <= memIn.pc;
            badVAddr <= memIn.aluOut;
        end
    end

    // an unknown low address would leave the trap decision unknown
    assert property (@(posedge clk) disable iff (!arstN)
        (memIn.valid && (memIn.ldType != ldNone || memIn.stType != stNone))
            |-> !$isunknown(memIn.aluOut[1:0]));

endmodule

/* hw/memStage.sv */
`timescale 1ns/1ps

module memStage #(
    parameter int ramAddrBits = 8
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  stageWr,
    input  logic                  stageFlush,
    input  logic                  disWr,
    input  memStagePkg::exeMemBus exeIn,
    output memStagePkg::memWbBus  memOut,
    output logic                  flushException,
    output memStagePkg::excCode   excOut,
    output logic [31:0]           epc,
    output logic [31:0]           badVAddr
);
    import memStagePkg::*;

    exeMemBus    memIn;
    logic [3:0]  byteEn;
    logic [3:0]  ramByteEn;
    logic [31:0] wrData;
    logic [31:0] rdWord;
    logic [31:0] loadData;
    logic        addrErr;
    logic        commitOk;

    memStageReg memStageReg_inst (
        .clk        (clk),
        .arstN      (arstN),
        .stageWr    (stageWr),
        .stageFlush (stageFlush),
        .exeIn      (exeIn),
        .memIn      (memIn)
    );

    storeAlign storeAlign_inst (
        .stType    (memIn.stType),
        .addrLow   (memIn.aluOut[1:0]),
        .storeData (memIn.storeData),
        .byteEn    (byteEn),
        .wrData    (wrData)
    );

    memExcept memExcept_inst (
        .clk            (clk),
        .arstN          (arstN),
        .memIn          (memIn),
        .addrErr        (addrErr),
        .flushException (flushException),
        .excOut         (excOut),
        .epc            (epc),
        .badVAddr       (badVAddr)
    );

    // disWr kills both side effects, as during a stall
    assign commitOk  = memIn.valid && !disWr && !addrErr;
    assign ramByteEn = commitOk ? byteEn : 4'b0000;

    dataRam #(
        .ramAddrBits (ramAddrBits)
    ) dataRam_inst (
        .clk      (clk),
        .byteEn   (ramByteEn),
        .wrData   (wrData),
        .wordAddr (memIn.aluOut[ramAddrBits+1:2]),
        .rdWord   (rdWord)
    );

    loadAlign loadAlign_inst (
        .ldType   (memIn.ldType),
        .addrLow  (memIn.aluOut[1:0]),
        .rdWord   (rdWord),
        .loadData (loadData)
    );

    // forwarded result, load data or alu value
    always_comb begin
        memOut.result = (memIn.ldType != ldNone) ? loadData : memIn.aluOut;
        memOut.dst    = memIn.dst;
        memOut.regWr  = commitOk && memIn.regWr;
    end

    // memory is only touched by a store in the stage
    assert property (@(posedge clk) disable iff (!arstN)
        (ramByteEn != 4'b0000) |-> (memIn.stType != stNone));

endmodule

/* tb/memStageTb.sv */
`timescale 1ns/1ps

module memStageTb;
    import memStagePkg::*;

    localparam int ramAddrBits = 8;
    localparam int ramBytes = 4 * (2 ** ramAddrBits);
    // a few hundred cycles of tests plus a wide margin
    localparam int maxCycles = 2000;

    logic        clk;
    logic        arstN;
    logic        stageWr;
    logic        stageFlush;
    logic        disWr;
    exeMemBus    exeIn;
    memWbBus     memOut;
    logic        flushException;
    excCode      excOut;
    logic [31:0] epc;
    logic [31:0] badVAddr;

    // byte-wide reference copy of the data memory
    logic [7:0]  refMem [ramBytes];
    integer      seed;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] pcCnt = 32'h0040_0000;
    exeMemBus    nop;

    memStage #(
        .ramAddrBits (ramAddrBits)
    ) memStage_inst (
        .clk            (clk),
        .arstN          (arstN),
        .stageWr        (stageWr),
        .stageFlush     (stageFlush),
        .disWr          (disWr),
        .exeIn          (exeIn),
        .memOut         (memOut),
        .flushException (flushException),
        .excOut         (excOut),
        .epc            (epc),
        .badVAddr       (badVAddr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= maxCycles) begin
            $display("timeout, tests did not finish within %0d cycles", maxCycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // builds a valid instruction with the next pc
    function automatic exeMemBus makeInstr(input logic [31:0] addr, input logic [31:0] data,
                                           input loadType ld, input storeType st,
                                           input logic [4:0] dst, input logic regWr);
        exeMemBus ins;
        ins.valid     = 1'b1;
        ins.pc        = pcCnt;
        ins.aluOut    = addr;
        ins.storeData = data;
        ins.ldType    = ld;
        ins.stType    = st;
        ins.dst       = dst;
        ins.regWr     = regWr;
        pcCnt         = pcCnt + 32'd4;
        return ins;
    endfunction

    // halfwords need an even address and words a multiple of four
    function automatic logic isMisaligned(input exeMemBus ins);
        logic half;
        logic word;
        half = (ins.ldType == ldHalf) || (ins.ldType == ldHalfU) || (ins.stType == stHalf);
        word = (ins.ldType == ldWord) || (ins.stType == stWord);
        return (half && ins.aluOut[0]) || (word && (ins.aluOut[1:0] != 2'b00));
    endfunction

    function automatic logic [31:0] expectResult(input exeMemBus ins);
        int          idx;
        logic [7:0]  b;
        logic [15:0] h;
        idx = ins.aluOut[ramAddrBits+1:0];
        b = refMem[idx];
        h = {refMem[idx+1], refMem[idx]};
        case (ins.ldType)
            ldByte:  return {{24{b[7]}}, b};
            ldByteU: return {24'd0, b};
            ldHalf:  return {{16{h[15]}}, h};
            ldHalfU: return {16'd0, h};
            ldWord:  return {refMem[idx+3], refMem[idx+2], h};
            default: return ins.aluOut;
        endcase
    endfunction

    task automatic updateModel(input exeMemBus ins);
        int idx;
        idx = ins.aluOut[ramAddrBits+1:0];
        if (ins.stType == stByte) begin
            refMem[idx] = ins.storeData[7:0];
        end else if (ins.stType == stHalf) begin
            refMem[idx]   = ins.storeData[7:0];
            refMem[idx+1] = ins.storeData[15:8];
        end else if (ins.stType == stWord) begin
            for (int i = 0; i < 4; i++) begin
                refMem[idx+i] = ins.storeData[8*i +: 8];
            end
        end
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // one instruction through the stage and checked while it sits there
    task automatic runInstr(input exeMemBus ins, input logic dis);
        logic   expErr;
        logic   expRegWr;
        excCode expExc;
        expErr   = ins.valid && isMisaligned(ins);
        expRegWr = ins.valid && ins.regWr && !dis && !expErr;
        if (!expErr) begin
            expExc = excNone;
        end else if (ins.stType != stNone) begin
            expExc = excAdES;
        end else begin
            expExc = excAdEL;
        end
        @(posedge clk);
        exeIn      <= ins;
        stageWr    <= 1'b1;
        stageFlush <= 1'b0;
        @(posedge clk);
        exeIn <= nop;
        disWr <= dis;
        @(negedge clk);
        compare("memOut.regWr", expRegWr, memOut.regWr);
        compare("memOut.dst", ins.dst, memOut.dst);
        compare("flushException", expErr, flushException);
        compare("excOut", expExc, excOut);
        if (!expErr) begin
            compare("memOut.result", expectResult(ins), memOut.result);
        end
        if (ins.valid && !dis && !expErr) begin
            updateModel(ins);
        end
        if (expErr) begin
            @(posedge clk);
            @(negedge clk);
            compare("epc", ins.pc, epc);
            compare("badVAddr", ins.aluOut, badVAddr);
        end
    endtask

    task automatic resetValues();
        int startErr;
        startErr = errors;
        @(negedge clk);
        compare("memOut.regWr", 1'b0, memOut.regWr);
        compare("flushException", 1'b0, flushException);
        compare("excOut", excNone, excOut);
        compare("epc", 32'd0, epc);
        compare("badVAddr", 32'd0, badVAddr);
        $display("resetValues finished, %0d errors", errors - startErr);
    endtask

    task automatic wordRoundTrip();
        logic [31:0] addrs [6];
        int          startErr;
        startErr = errors;
        for (int i = 0; i < 6; i++) begin
            addrs[i] = $random(seed) & 32'hffff_fffc;
            runInstr(makeInstr(addrs[i], $random(seed), ldNone, stWord, 5'd0, 1'b0), 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            runInstr(makeInstr(addrs[i], 32'd0, ldWord, stNone, 5'(8 + i), 1'b1), 1'b0);
        end
        // plain alu results pass straight through
        for (int i = 0; i < 4; i++) begin
            runInstr(makeInstr($random(seed), 32'd0, ldNone, stNone, 5'(16 + i), 1'b1), 1'b0);
        end
        $display("wordRoundTrip finished, %0d errors", errors - startErr);
    endtask

    task automatic subWordAccess();
        logic [31:0] base;
        logic [31:0] data;
        int          startErr;
        startErr = errors;
        base = $random(seed) & 32'hffff_fffc;
        runInstr(makeInstr(base, $random(seed), ldNone, stWord, 5'd0, 1'b0), 1'b0);
        for (int lane = 0; lane < 4; lane++) begin
            data = $random(seed);
            // alternate the sign bit so both extensions get exercised
            data[7] = (lane % 2 == 1);
            runInstr(makeInstr(base + lane, data, ldNone, stByte, 5'd0, 1'b0), 1'b0);
        end
        for (int lane = 0; lane < 4; lane++) begin
            runInstr(makeInstr(base + lane, 32'd0, ldByte, stNone, 5'd4, 1'b1), 1'b0);
            runInstr(makeInstr(base + lane, 32'd0, ldByteU, stNone, 5'd5, 1'b1), 1'b0);
        end
        for (int half = 0; half < 2; half++) begin
            data = $random(seed);
            data[15] = (half == 0);
            runInstr(makeInstr(base + 2 * half, data, ldNone, stHalf, 5'd0, 1'b0), 1'b0);
        end
        for (int half = 0; half < 2; half++) begin
            runInstr(makeInstr(base + 2 * half, 32'd0, ldHalf, stNone, 5'd6, 1'b1), 1'b0);
            runInstr(makeInstr(base + 2 * half, 32'd0, ldHalfU, stNone, 5'd7, 1'b1), 1'b0);
        end
        runInstr(makeInstr(base, 32'd0, ldWord, stNone, 5'd9, 1'b1), 1'b0);
        $display("subWordAccess finished, %0d errors", errors - startErr);
    endtask

    task automatic addressErrors();
        logic [31:0] base;
        int          startErr;
        startErr = errors;
        base = $random(seed) & 32'hffff_fffc;
        runInstr(makeInstr(base, $random(seed), ldNone, stWord, 5'd0, 1'b0), 1'b0);
        runInstr(makeInstr(base + 1, 32'd0, ldHalf, stNone, 5'd3, 1'b1), 1'b0);
        runInstr(makeInstr(base + 2, 32'd0, ldWord, stNone, 5'd3, 1'b1), 1'b0);
        runInstr(makeInstr(base + 3, 32'd0, ldHalfU, stNone, 5'd3, 1'b1), 1'b0);
        // misaligned stores must leave the word untouched
        runInstr(makeInstr(base + 1, $random(seed), ldNone, stWord, 5'd0, 1'b0), 1'b0);
        runInstr(makeInstr(base + 3, $random(seed), ldNone, stHalf, 5'd0, 1'b0), 1'b0);
        runInstr(makeInstr(base, 32'd0, ldWord, stNone, 5'd10, 1'b1), 1'b0);
        $display("addressErrors finished, %0d errors", errors - startErr);
    endtask

    task automatic writeDisable();
        logic [31:0] base;
        int          startErr;
        startErr = errors;
        base = $random(seed) & 32'hffff_fffc;
        runInstr(makeInstr(base, $random(seed), ldNone, stWord, 5'd0, 1'b0), 1'b0);
        runInstr(makeInstr(base, $random(seed), ldNone, stWord, 5'd0, 1'b0), 1'b1);
        runInstr(makeInstr(base + 2, $random(seed), ldNone, stByte, 5'd0, 1'b0), 1'b1);
        runInstr(makeInstr($random(seed), 32'd0, ldNone, stNone, 5'd11, 1'b1), 1'b1);
        runInstr(makeInstr(base, 32'd0, ldWord, stNone, 5'd12, 1'b1), 1'b0);
        $display("writeDisable finished, %0d errors", errors - startErr);
    endtask

    task automatic stallAndFlush();
        exeMemBus held;
        exeMemBus next;
        exeMemBus bad;
        int       startErr;
        startErr = errors;
        held = makeInstr($random(seed), 32'd0, ldNone, stNone, 5'd21, 1'b1);
        next = makeInstr($random(seed), 32'd0, ldNone, stNone, 5'd22, 1'b1);
        bad  = makeInstr(($random(seed) & 32'hffff_fffc) | 32'd2, 32'd0, ldWord, stNone,
                         5'd23, 1'b1);
        @(posedge clk);
        exeIn      <= held;
        stageWr    <= 1'b1;
        stageFlush <= 1'b0;
        disWr      <= 1'b0;
        @(posedge clk);
        exeIn   <= next;
        stageWr <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            compare("memOut.result", held.aluOut, memOut.result);
            compare("memOut.dst", held.dst, memOut.dst);
            compare("memOut.regWr", 1'b1, memOut.regWr);
        end
        @(posedge clk);
        stageWr <= 1'b1;
        @(posedge clk);
        exeIn      <= bad;
        stageFlush <= 1'b1;
        @(negedge clk);
        compare("memOut.result", next.aluOut, memOut.result);
        compare("memOut.dst", next.dst, memOut.dst);
        // bad is dropped at the flush edge
        @(posedge clk);
        exeIn      <= nop;
        stageFlush <= 1'b0;
        @(negedge clk);
        compare("memOut.regWr", 1'b0, memOut.regWr);
        compare("flushException", 1'b0, flushException);
        compare("excOut", excNone, excOut);
        // now let bad in and flush it out of the stage
        @(posedge clk);
        exeIn <= bad;
        @(posedge clk);
        exeIn      <= nop;
        stageFlush <= 1'b1;
        @(negedge clk);
        compare("flushException", 1'b1, flushException);
        @(posedge clk);
        stageFlush <= 1'b0;
        @(negedge clk);
        compare("memOut.regWr", 1'b0, memOut.regWr);
        compare("flushException", 1'b0, flushException);
        compare("excOut", excNone, excOut);
        $display("stallAndFlush finished, %0d errors", errors - startErr);
    endtask

    initial begin
        seed       = 32'hbd33_6ac9;
        nop        = '0;
        arstN      = 1'b0;
        stageWr    = 1'b0;
        stageFlush = 1'b0;
        disWr      = 1'b0;
        exeIn      = '0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        resetValues();
        wordRoundTrip();
        subWordAccess();
        addressErrors();
        writeDisable();
        stallAndFlush();
        @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* build.f */
hw/memStagePkg.sv
hw/memStageReg.sv
hw/storeAlign.sv
hw/loadAlign.sv
hw/dataRam.sv
hw/memExcept.sv
hw/memStage.sv
tb/memStageTb.sv
